// ==== filelist.f ====
verilog/snake_pkg.sv
verilog/pixel_scan.sv
verilog/game_control.sv
verilog/snake_body.sv
verilog/food_gen.sv
verilog/pixel_render.sv
verilog/snake_game_top.sv
tb/tb_snake_game.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator and run the snake game testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_snake_game \
    -f filelist.f -o tb_snake_game || exit 1
sim_out="$(./obj_dir/tb_snake_game)" || exit 1
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Test passed" && exit 0 || exit 1

// ==== tb/tb_snake_game.sv ====
`timescale 1ns/1ps

module tb_snake_game;

    localparam int H_ACTIVE = 800;
    localparam int V_ACTIVE = 600;
    localparam int STEP_LOG2 = 12;
    localparam int CLK_PERIOD = 8;
    localparam int FRAME_CYCLES = H_ACTIVE * V_ACTIVE;
    localparam int STEP_CYCLES = 1 << STEP_LOG2;
    localparam int BOX_Y_TOP = 250;
    localparam longint WATCHDOG_NS =
        longint'(5 * FRAME_CYCLES + 40 * STEP_CYCLES) * CLK_PERIOD;

    logic CLK;
    logic RESET;
    logic btn_left;
    logic btn_right;
    logic btn_up;
    logic btn_down;
    snake_pkg::coord_t pixel_x;
    snake_pkg::coord_t pixel_y;
    snake_pkg::rgb_t pixel_rgb;
    logic frame_start;
    snake_pkg::len_t length;
    logic game_over;

    int err_rgb = 0;
    int err_coord = 0;
    int err_len = 0;
    int err_bit = 0;
    int err_other = 0;
    int last_length = snake_pkg::LEN_INIT;
    int frame_gap = 0;
    logic frame_seen = 1'b0;

    // food model state
    int rnd_model = 0;
    int food_phase = 0;
    logic play_model = 1'b0;
    int food_x_prev = 0;
    int food_y_prev = 0;

    snake_game_top #(
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .STEP_LOG2 (STEP_LOG2)
    ) UUT (
        .CLK         (CLK),
        .RESET       (RESET),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_up      (btn_up),
        .btn_down    (btn_down),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_rgb   (pixel_rgb),
        .frame_start (frame_start),
        .length      (length),
        .game_over   (game_over)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic in_arena_box(input int x, input int y);
        return (x > -int'(snake_pkg::ARENA_X_MAX)) && (x < int'(snake_pkg::ARENA_X_MAX)) &&
               (y > int'(snake_pkg::ARENA_Y_MIN)) && (y < BOX_Y_TOP);
    endfunction

    // snake stands still in its start layout until a direction is set
    function automatic logic on_start_body(input int x, input int y);
        int k;
        int sx;
        logic hit;
        hit = 1'b0;
        for (k = 0; k < snake_pkg::LEN_INIT; k++) begin
            sx = (k < 4) ? (4 - k) * snake_pkg::SEG_SPACING : 0;
            if ((x - sx) * (x - sx) + y * y < snake_pkg::SEG_RSQ) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic snake_pkg::rgb_t expected_color(input snake_pkg::game_state_e st,
                                                       input int x, input int y,
                                                       input logic on_food);
        if (st == snake_pkg::GAME_IDLE) begin
            return snake_pkg::COLOR_WHITE;
        end
        if (st == snake_pkg::GAME_OVER) begin
            return snake_pkg::COLOR_RED;
        end
        if (on_start_body(x, y)) begin
            return snake_pkg::COLOR_GREEN;
        end
        if (on_food) begin
            return snake_pkg::COLOR_RED;
        end
        if (in_arena_box(x, y)) begin
            return snake_pkg::COLOR_BLACK;
        end
        return snake_pkg::COLOR_WHITE;
    endfunction

    task automatic check_rgb(input string name, input snake_pkg::rgb_t actual,
                             input snake_pkg::rgb_t expected);
        if (actual !== expected) begin
            err_rgb++;
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_coord(input string name, input snake_pkg::coord_t actual,
                               input snake_pkg::coord_t expected);
        if (actual !== expected) begin
            err_coord++;
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_len(input string name, input snake_pkg::len_t actual,
                             input snake_pkg::len_t expected);
        if (actual !== expected) begin
            err_len++;
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            err_bit++;
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // waits for the next frame_start and checks every pixel of that frame
    task automatic scan_frame(input snake_pkg::game_state_e st, output int waited);
        int i;
        int ex;
        int ey;
        int fdx;
        int fdy;
        logic on_food;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (frame_start !== 1'b1);
        for (i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) begin
                @(negedge CLK);
            end
            ex = i % H_ACTIVE - H_ACTIVE / 2;
            ey = V_ACTIVE / 2 - i / H_ACTIVE;
            check_coord("pixel_x", pixel_x, snake_pkg::coord_t'(ex));
            check_coord("pixel_y", pixel_y, snake_pkg::coord_t'(ey));
            check_bit("frame_start", frame_start, i == 0);
            fdx = ex - food_x_prev;
            fdy = ey - food_y_prev;
            on_food = (st == snake_pkg::GAME_PLAY) &&
                      (fdx * fdx + fdy * fdy < snake_pkg::FOOD_RSQ);
            check_rgb("pixel_rgb", pixel_rgb, expected_color(st, ex, ey, on_food));
        end
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        RESET <= 1'b1;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
    endtask

    task automatic press_buttons(input logic l, input logic r, input logic u, input logic d,
                                 input int cycles, output longint t_drive);
        @(posedge CLK);
        t_drive = $time;
        btn_left <= l;
        btn_right <= r;
        btn_up <= u;
        btn_down <= d;
        repeat (cycles) @(posedge CLK);
        btn_left <= 1'b0;
        btn_right <= 1'b0;
        btn_up <= 1'b0;
        btn_down <= 1'b0;
    endtask

    task automatic wait_game_over(input int limit, output longint t_seen);
        int n;
        logic found;
        n = 0;
        found = 1'b0;
        t_seen = 0;
        while (!found && n < limit) begin
            @(negedge CLK);
            n++;
            if (game_over === 1'b1) begin
                found = 1'b1;
                t_seen = $time;
            end
        end
        if (!found) begin
            err_other++;
            $display("game_over did not rise within %0d cycles", limit);
        end
    endtask

    // game_over follows one cycle after the step that reaches the wall
    task automatic verify_step_count(input string name, input longint t_press,
                                     input longint t_seen, input int steps);
        longint cycles;
        if (t_seen != 0) begin
            cycles = (t_seen - t_press) / CLK_PERIOD;
            if (cycles <= longint'((steps - 1) * STEP_CYCLES) ||
                cycles > longint'(steps * STEP_CYCLES + 3)) begin
                err_other++;
                $display("%s: game_over came %0d cycles after the press, not at step %0d",
                         name, cycles, steps);
            end
        end
    endtask

    function automatic int error_total();
        return err_rgb + err_coord + err_len + err_bit + err_other;
    endfunction

    task automatic report_counts();
        $display("errors: pixel_rgb %0d, coordinates %0d, length %0d, frame_start %0d, other %0d",
                 err_rgb, err_coord, err_len, err_bit, err_other);
    endtask

    // length and frame spacing over the whole run
    always @(negedge CLK) begin
        if (RESET) begin
            last_length = snake_pkg::LEN_INIT;
            frame_seen = 1'b0;
            frame_gap = 0;
        end else begin
            if (int'(length) < last_length) begin
                err_len++;
                $display("FAILED at %0t ns: length = %0d, expected at least %0d",
                         $time, length, last_length);
            end
            if (int'(length) < snake_pkg::LEN_INIT || int'(length) > snake_pkg::SEG_MAX) begin
                err_len++;
                $display("FAILED at %0t ns: length = %0d, expected %0d to %0d",
                         $time, length, snake_pkg::LEN_INIT, snake_pkg::SEG_MAX);
            end
            last_length = int'(length);
            if (frame_seen) begin
                frame_gap = frame_gap + 1;
            end
            if (frame_start === 1'b1) begin
                if (frame_seen && frame_gap != FRAME_CYCLES) begin
                    err_bit++;
                    $display("FAILED at %0t ns: frame_start gap = %0d, expected %0d",
                             $time, frame_gap, FRAME_CYCLES);
                end
                frame_seen = 1'b1;
                frame_gap = 0;
            end
        end
    end

    // food placement while the snake still stands in its start layout
    // phase 0 waits for play, 1 places, 2 holds
    always @(posedge CLK) begin : food_model
        int fx;
        int fy;
        int hx;
        logic eaten;
        hx = 4 * snake_pkg::SEG_SPACING;
        if (food_phase == 1) begin
            fx = (rnd_model % 16) * 20;
            fy = (rnd_model % 11) * 20;
        end else if (food_phase == 2) begin
            fx = food_x_prev;
            fy = food_y_prev;
        end else begin
            fx = 0;
            fy = 0;
        end
        eaten = play_model && ((hx - fx) * (hx - fx) + fy * fy < snake_pkg::EAT_DSQ);
        // the render stage shows this food with the next pixel
        food_x_prev <= fx;
        food_y_prev <= fy;
        if (RESET) begin
            rnd_model <= 0;
            food_phase <= 0;
            play_model <= 1'b0;
        end else begin
            rnd_model <= (rnd_model >= 500) ? -500 : rnd_model + 1;
            if (btn_left || btn_right || btn_up || btn_down) begin
                play_model <= 1'b1;
            end
            case (food_phase)
                0: if (play_model) food_phase <= 1;
                1: food_phase <= 2;
                default: if (eaten) food_phase <= 1;
            endcase
        end
    end

    initial begin : stimulus
        int waited;
        int hold_a;
        int hold_b;
        longint t_press;
        longint t_left;
        longint t_over;
        void'($urandom(32'h7738_4ebc));
        CLK = 1'b0;
        RESET = 1'b1;
        btn_left = 1'b0;
        btn_right = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        // first pixel leaves the render stage one cycle after reset ends
        scan_frame(snake_pkg::GAME_IDLE, waited);
        if (waited != 2) begin
            err_other++;
            $display("first frame started %0d cycles after reset instead of 2", waited);
        end
        check_len("length", length, snake_pkg::len_t'(snake_pkg::LEN_INIT));

        // a one-cycle press starts play with no direction set
        press_buttons(1'b0, 1'b0, 1'b0, 1'b1, 1, t_press);
        scan_frame(snake_pkg::GAME_PLAY, waited);

        // right and then a held reversal that must be ignored
        hold_a = 1 + int'($urandom % 8);
        hold_b = STEP_CYCLES + int'($urandom % (4 * STEP_CYCLES));
        press_buttons(1'b0, 1'b1, 1'b0, 1'b0, hold_a, t_press);
        press_buttons(1'b1, 1'b0, 1'b0, 1'b0, hold_b, t_left);
        wait_game_over(11 * STEP_CYCLES, t_over);
        verify_step_count("right run", t_press, t_over, 10);
        scan_frame(snake_pkg::GAME_OVER, waited);

        // second game heading up from the start layout
        apply_reset();
        hold_a = 2 + int'($urandom % 8);
        press_buttons(1'b0, 1'b0, 1'b1, 1'b0, hold_a, t_press);
        wait_game_over(9 * STEP_CYCLES, t_over);
        verify_step_count("up run", t_press, t_over, 8);

        report_counts();
        if (error_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d ns", WATCHDOG_NS);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog/food_gen.sv ====
`timescale 1ns/1ps

module food_gen (
    input  logic                    CLK,
    input  logic                    RESET,
    input  snake_pkg::game_state_e  state,
    input  logic                    food_eaten,
    output snake_pkg::coord_t       food_x,
    output snake_pkg::coord_t       food_y
);

    typedef enum logic [1:0] {
        F_INIT,
        F_GEN,
        F_WAIT
    } food_state_e;

    food_state_e f_state;
    food_state_e f_state_next;
    logic signed [9:0] rnd;
    snake_pkg::coord_t held_x;
    snake_pkg::coord_t held_y;
    logic out_of_arena;

    // free-running, -500 up to 500
    always_ff @(posedge CLK) begin
        if (RESET) begin
            rnd <= '0;
        end else if (rnd >= 10'sd500) begin
            rnd <= -10'sd500;
        end else begin
            rnd <= rnd + 1'b1;
        end
    end

    assign out_of_arena = (held_x > snake_pkg::ARENA_X_MAX) ||
                          (held_x < -snake_pkg::ARENA_X_MAX) ||
                          (held_y > snake_pkg::ARENA_Y_MAX) ||
                          (held_y < snake_pkg::ARENA_Y_MIN);

    always_comb begin
        f_state_next = f_state;
        case (f_state)
            F_INIT:  if (state == snake_pkg::GAME_PLAY) f_state_next = F_GEN;
            F_GEN:   f_state_next = F_WAIT;
            default: if (food_eaten || out_of_arena) f_state_next = F_GEN;
        endcase
    end

    // new spot shows in GEN itself, then it is held
    always_comb begin
        case (f_state)
            F_INIT: begin
                food_x = '0;
                food_y = '0;
            end
            F_GEN: begin
                food_x = snake_pkg::coord_t'((int'(rnd) % 16) * 20);
                food_y = snake_pkg::coord_t'((int'(rnd) % 11) * 20);
            end
            default: begin
                food_x = held_x;
                food_y = held_y;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        held_x <= food_x;
        held_y <= food_y;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            f_state <= F_INIT;
        end else begin
            f_state <= f_state_next;
        end
    end

endmodule

// ==== verilog/game_control.sv ====
`timescale 1ns/1ps

module game_control (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  logic                    btn_up,
    input  logic                    btn_down,
    input  snake_pkg::coord_t       head_x,
    input  snake_pkg::coord_t       head_y,
    output snake_pkg::game_state_e  state,
    output snake_pkg::dir_e         dir
);

    logic any_btn;
    logic wall_hit;
    snake_pkg::game_state_e state_next;
    snake_pkg::dir_e dir_next;

    assign any_btn = btn_left | btn_right | btn_up | btn_down;

    assign wall_hit = (head_x >= snake_pkg::ARENA_X_MAX) ||
                      (head_x <= -snake_pkg::ARENA_X_MAX) ||
                      (head_y >= snake_pkg::ARENA_Y_MAX) ||
                      (head_y <= snake_pkg::ARENA_Y_MIN);

    always_comb begin
        state_next = state;
        case (state)
            snake_pkg::GAME_IDLE: if (any_btn) state_next = snake_pkg::GAME_PLAY;
            snake_pkg::GAME_PLAY: if (wall_hit) state_next = snake_pkg::GAME_OVER;
            // over is left only through reset
            default: state_next = snake_pkg::GAME_OVER;
        endcase
    end

    // a button that would reverse the snake keeps the current direction
    always_comb begin
        dir_next = dir;
        if (state == snake_pkg::GAME_PLAY) begin
            if (btn_left || btn_right) begin
                case (dir)
                    snake_pkg::DIR_RIGHT, snake_pkg::DIR_LEFT: dir_next = dir;
                    snake_pkg::DIR_NONE: dir_next = snake_pkg::DIR_RIGHT;
                    default: dir_next = btn_left ? snake_pkg::DIR_LEFT : snake_pkg::DIR_RIGHT;
                endcase
            end else if (btn_up || btn_down) begin
                case (dir)
                    snake_pkg::DIR_UP, snake_pkg::DIR_DOWN: dir_next = dir;
                    default: dir_next = btn_up ? snake_pkg::DIR_UP : snake_pkg::DIR_DOWN;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= snake_pkg::GAME_IDLE;
            dir <= snake_pkg::DIR_NONE;
        end else begin
            state <= state_next;
            dir <= dir_next;
        end
    end

endmodule

// ==== verilog/pixel_render.sv ====
`timescale 1ns/1ps

module pixel_render (
    input  logic                    CLK,
    input  logic                    RESET,
    input  snake_pkg::coord_t       scan_x,
    input  snake_pkg::coord_t       scan_y,
    input  logic                    scan_first,
    input  snake_pkg::game_state_e  state,
    input  snake_pkg::coord_t       seg_x [snake_pkg::SEG_MAX],
    input  snake_pkg::coord_t       seg_y [snake_pkg::SEG_MAX],
    input  snake_pkg::len_t         length,
    input  snake_pkg::coord_t       food_x,
    input  snake_pkg::coord_t       food_y,
    output snake_pkg::coord_t       pixel_x,
    output snake_pkg::coord_t       pixel_y,
    output snake_pkg::rgb_t         pixel_rgb,
    output logic                    frame_start
);

    // drawn box reaches above the top wall
    localparam snake_pkg::coord_t BOX_Y_TOP = 12'sd250;

    logic body_hit;
    logic food_hit;
    logic in_box;
    int food_dx;
    int food_dy;
    snake_pkg::rgb_t color;

    always_comb begin : body_test
        int dx;
        int dy;
        body_hit = 1'b0;
        for (int i = 0; i < snake_pkg::SEG_MAX; i++) begin
            dx = int'(scan_x) - int'(seg_x[i]);
            dy = int'(scan_y) - int'(seg_y[i]);
            // only live segments are drawn
            if (i < int'(length) && dx * dx + dy * dy < snake_pkg::SEG_RSQ) begin
                body_hit = 1'b1;
            end
        end
    end

    assign food_dx = int'(scan_x) - int'(food_x);
    assign food_dy = int'(scan_y) - int'(food_y);
    assign food_hit = (food_dx * food_dx + food_dy * food_dy < snake_pkg::FOOD_RSQ);

    assign in_box = (scan_x > -snake_pkg::ARENA_X_MAX) &&
                    (scan_x < snake_pkg::ARENA_X_MAX) &&
                    (scan_y > snake_pkg::ARENA_Y_MIN) &&
                    (scan_y < BOX_Y_TOP);

    always_comb begin
        case (state)
            snake_pkg::GAME_IDLE: color = snake_pkg::COLOR_WHITE;
            snake_pkg::GAME_PLAY: begin
                if (body_hit) begin
                    color = snake_pkg::COLOR_GREEN;
                end else if (food_hit) begin
                    color = snake_pkg::COLOR_RED;
                end else if (in_box) begin
                    color = snake_pkg::COLOR_BLACK;
                end else begin
                    color = snake_pkg::COLOR_WHITE;
                end
            end
            default: color = snake_pkg::COLOR_RED;
        endcase
    end

    // colour travels with its coordinate
    always_ff @(posedge CLK) begin
        pixel_x <= scan_x;
        pixel_y <= scan_y;
        pixel_rgb <= color;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= scan_first;
        end
    end

endmodule

// ==== verilog/pixel_scan.sv ====
`timescale 1ns/1ps

module pixel_scan #(
    parameter int H_ACTIVE = 800,
    parameter int V_ACTIVE = 600
) (
    input  logic               CLK,
    input  logic               RESET,
    output snake_pkg::coord_t  scan_x,
    output snake_pkg::coord_t  scan_y,
    output logic               scan_first
);

    localparam int COL_W = $clog2(H_ACTIVE);
    localparam int ROW_W = $clog2(V_ACTIVE);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    // row-major walk, one pixel per clock
    always_ff @(posedge CLK) begin
        if (RESET) begin
            col <= '0;
            row <= '0;
        end else if (col == COL_W'(H_ACTIVE - 1)) begin
            col <= '0;
            if (row == ROW_W'(V_ACTIVE - 1)) begin
                row <= '0;
            end else begin
                row <= row + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    // centred, up is positive
    assign scan_x = snake_pkg::coord_t'(col) - snake_pkg::coord_t'(H_ACTIVE / 2);
    assign scan_y = snake_pkg::coord_t'(V_ACTIVE / 2) - snake_pkg::coord_t'(row);
    assign scan_first = (col == '0) && (row == '0);

endmodule

// ==== verilog/snake_body.sv ====
`timescale 1ns/1ps

module snake_body #(
    parameter int STEP_LOG2 = 24
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  snake_pkg::game_state_e  state,
    input  snake_pkg::dir_e         dir,
    input  snake_pkg::coord_t       food_x,
    input  snake_pkg::coord_t       food_y,
    output snake_pkg::coord_t       seg_x [snake_pkg::SEG_MAX],
    output snake_pkg::coord_t       seg_y [snake_pkg::SEG_MAX],
    output snake_pkg::len_t         length,
    output logic                    food_eaten
);

    // hidden segments follow the fourth one
    localparam int TAIL_SRC = 3;
    localparam snake_pkg::coord_t STEP = snake_pkg::coord_t'(snake_pkg::STEP_PX);

    logic [STEP_LOG2-1:0] step_cnt;
    logic step_tick;
    int head_dx;
    int head_dy;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign step_tick = &step_cnt;

    always_ff @(posedge CLK) begin
        if (RESET || state != snake_pkg::GAME_PLAY) begin
            // start layout, head at 4 spacings to the right
            for (int i = 0; i < snake_pkg::SEG_MAX; i++) begin
                seg_x[i] <= (i < 4) ? snake_pkg::coord_t'((4 - i) * snake_pkg::SEG_SPACING)
                                    : '0;
                seg_y[i] <= '0;
            end
        end else if (step_tick && dir != snake_pkg::DIR_NONE) begin
            case (dir)
                snake_pkg::DIR_RIGHT: seg_x[0] <= seg_x[0] + STEP;
                snake_pkg::DIR_LEFT:  seg_x[0] <= seg_x[0] - STEP;
                snake_pkg::DIR_UP:    seg_y[0] <= seg_y[0] + STEP;
                default:              seg_y[0] <= seg_y[0] - STEP;
            endcase
            for (int i = 1; i < snake_pkg::SEG_MAX; i++) begin
                if (i >= int'(length)) begin
                    seg_x[i] <= seg_x[TAIL_SRC];
                    seg_y[i] <= seg_y[TAIL_SRC];
                end else begin
                    seg_x[i] <= seg_x[i-1];
                    seg_y[i] <= seg_y[i-1];
                end
            end
        end
    end

    // head to food distance
    assign head_dx = int'(seg_x[0]) - int'(food_x);
    assign head_dy = int'(seg_y[0]) - int'(food_y);
    assign food_eaten = (state == snake_pkg::GAME_PLAY) &&
                        (head_dx * head_dx + head_dy * head_dy < snake_pkg::EAT_DSQ);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            length <= snake_pkg::len_t'(snake_pkg::LEN_INIT);
        end else if (food_eaten && length < snake_pkg::len_t'(snake_pkg::SEG_MAX)) begin
            length <= length + 1'b1;
        end
    end

endmodule

// ==== verilog/snake_game_top.sv ====
`timescale 1ns/1ps

module snake_game_top #(
    parameter int H_ACTIVE = 800,
    parameter int V_ACTIVE = 600,
    parameter int STEP_LOG2 = 24
) (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               btn_left,
    input  logic               btn_right,
    input  logic               btn_up,
    input  logic               btn_down,
    output snake_pkg::coord_t  pixel_x,
    output snake_pkg::coord_t  pixel_y,
    output snake_pkg::rgb_t    pixel_rgb,
    output logic               frame_start,
    output snake_pkg::len_t    length,
    output logic               game_over
);

    snake_pkg::coord_t scan_x;
    snake_pkg::coord_t scan_y;
    logic scan_first;
    snake_pkg::game_state_e state;
    snake_pkg::dir_e dir;
    snake_pkg::coord_t seg_x [snake_pkg::SEG_MAX];
    snake_pkg::coord_t seg_y [snake_pkg::SEG_MAX];
    snake_pkg::coord_t food_x;
    snake_pkg::coord_t food_y;
    logic food_eaten;

    assign game_over = (state == snake_pkg::GAME_OVER);

    pixel_scan #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_scan (
        .CLK        (CLK),
        .RESET      (RESET),
        .scan_x     (scan_x),
        .scan_y     (scan_y),
        .scan_first (scan_first)
    );

    // head is segment 0
    game_control u_control (
        .CLK       (CLK),
        .RESET     (RESET),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .head_x    (seg_x[0]),
        .head_y    (seg_y[0]),
        .state     (state),
        .dir       (dir)
    );

    snake_body #(
        .STEP_LOG2 (STEP_LOG2)
    ) u_body (
        .CLK        (CLK),
        .RESET      (RESET),
        .state      (state),
        .dir        (dir),
        .food_x     (food_x),
        .food_y     (food_y),
        .seg_x      (seg_x),
        .seg_y      (seg_y),
        .length     (length),
        .food_eaten (food_eaten)
    );

    food_gen u_food (
        .CLK        (CLK),
        .RESET      (RESET),
        .state      (state),
        .food_eaten (food_eaten),
        .food_x     (food_x),
        .food_y     (food_y)
    );

    pixel_render u_render (
        .CLK         (CLK),
        .RESET       (RESET),
        .scan_x      (scan_x),
        .scan_y      (scan_y),
        .scan_first  (scan_first),
        .state       (state),
        .seg_x       (seg_x),
        .seg_y       (seg_y),
        .length      (length),
        .food_x      (food_x),
        .food_y      (food_y),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_rgb   (pixel_rgb),
        .frame_start (frame_start)
    );

endmodule

// ==== verilog/snake_pkg.sv ====
package snake_pkg;

    typedef logic signed [11:0] coord_t;
    typedef logic [5:0] rgb_t;
    typedef logic [3:0] len_t;

    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLAY,
        GAME_OVER
    } game_state_e;

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_RIGHT,
        DIR_LEFT,
        DIR_UP,
        DIR_DOWN
    } dir_e;

    // snake geometry
    localparam int SEG_MAX = 10;
    localparam int LEN_INIT = 5;
    localparam int STEP_PX = 30;
    localparam int SEG_SPACING = 20;

    // compared against squared distances
    localparam int SEG_RSQ = 400;
    localparam int FOOD_RSQ = 225;
    localparam int EAT_DSQ = 1200;

    // walls of the arena
    localparam coord_t ARENA_X_MAX = 12'sd375;
    localparam coord_t ARENA_Y_MAX = 12'sd225;
    localparam coord_t ARENA_Y_MIN = -12'sd275;

    // 2 bits each of red, green, blue
    localparam rgb_t COLOR_WHITE = 6'b11_11_11;
    localparam rgb_t COLOR_BLACK = 6'b00_00_00;
    localparam rgb_t COLOR_GREEN = 6'b00_11_00;
    localparam rgb_t COLOR_RED = 6'b11_00_00;

endpackage
